// ==== logic/bus_timing_pkg.sv ====
`default_nettype none

package bus_timing_pkg;

	// CLK_IN cycles per bus half-period.
	localparam int clk_divider = 10;
	// bus clocks in the reset phase.
	localparam int reset_cycles = 4;
	// start wait and disable phase, in half-periods.
	localparam int start_half_cycles = 6;

	localparam int div_bits = $clog2(clk_divider);
	localparam int rep_max = (start_half_cycles > reset_cycles) ?
		start_half_cycles : reset_cycles;
	localparam int rep_bits = $clog2(rep_max);

	typedef enum logic [3:0]
	{
		bus_idle       = 4'd0,
		wait_start_pos = 4'd1,
		wait_start_neg = 4'd2,
		arb_res_pos    = 4'd3,
		arb_res_neg    = 4'd4,
		drive1_pos     = 4'd5,
		drive1_neg     = 4'd6,
		latch1_pos     = 4'd7,
		latch1_neg     = 4'd8,
		drive2_pos     = 4'd9,
		drive2_neg     = 4'd10,
		latch2_pos     = 4'd11,
		latch2_neg     = 4'd12,
		bus_reset_pos  = 4'd13,
		bus_reset_neg  = 4'd14,
		bus_disable    = 4'd15
	} mediator_state_e;

endpackage

`default_nettype wire

// ==== logic/bus_frame_pkg.sv ====
`default_nettype none

package bus_frame_pkg;

	localparam int word_bits = 16;
	localparam int addr_bits = 8;
	localparam int count_bits = 8;
	localparam int bit_index_bits = $clog2(word_bits);

	// header view of a word.
	typedef struct packed
	{
		logic [addr_bits-1:0]  dest_addr;
		logic [count_bits-1:0] word_count;
	} bus_header_t;

	// first word of a frame is a header, the rest raw payload.
	typedef union packed
	{
		bus_header_t          header;
		logic [word_bits-1:0] raw;
	} bus_word_u;

endpackage

`default_nettype wire

// ==== logic/half_cycle_timer.sv ====
`default_nettype none

module half_cycle_timer
	import bus_timing_pkg::*;
(
	input  logic CLK_IN,
	input  logic RESET,
	input  logic run,
	input  logic load_start,
	input  logic load_reset,
	input  logic step,
	output logic tick,
	output logic repeat_zero
);

	logic [div_bits-1:0] div_cnt;
	logic [rep_bits-1:0] rep_cnt;

	// divider reloads at zero and parks at the top when stopped.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			div_cnt <= div_bits'(clk_divider - 1);
		else if (!run)
			div_cnt <= div_bits'(clk_divider - 1);
		else if (div_cnt == '0)
			div_cnt <= div_bits'(clk_divider - 1);
		else
			div_cnt <= div_cnt - 1'b1;
	end

	assign tick = run && (div_cnt == '0);

	// repeat count for start, reset and disable phases.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			rep_cnt <= rep_bits'(start_half_cycles - 1);
		else if (load_start)
			rep_cnt <= rep_bits'(start_half_cycles - 1);
		else if (load_reset)
			rep_cnt <= rep_bits'(reset_cycles - 1);
		else if (step && (rep_cnt != '0))
			rep_cnt <= rep_cnt - 1'b1;
	end

	assign repeat_zero = (rep_cnt == '0);

endmodule

`default_nettype wire

// ==== logic/mediator_fsm.sv ====
`default_nettype none

module mediator_fsm
	import bus_timing_pkg::*;
(
	input  logic CLK_IN,
	input  logic RESET,
	input  logic din_low,
	input  logic interject,
	input  logic tick,
	input  logic repeat_zero,
	output logic CLK_OUT,
	output logic hold,
	output logic run,
	output logic load_start,
	output logic load_reset,
	output logic step,
	output logic sample_first,
	output logic sample_second,
	output logic bus_active
);

	mediator_state_e state;
	mediator_state_e next_state;
	logic reset_armed;
	logic reset_commit;

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			state <= bus_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			bus_idle:
				if (din_low)
					next_state = wait_start_pos;
			wait_start_pos:
				if (tick && repeat_zero)
					next_state = wait_start_neg;
			wait_start_neg:
				if (tick)
					next_state = arb_res_pos;
			arb_res_pos:
				if (tick)
					next_state = arb_res_neg;
			arb_res_neg:
				if (tick)
					next_state = drive1_pos;
			drive1_pos:
				if (tick)
					next_state = drive1_neg;
			drive1_neg:
				if (tick)
					next_state = latch1_pos;
			latch1_pos:
				if (tick)
					next_state = latch1_neg;
			latch1_neg:
				if (tick)
					next_state = drive2_pos;
			drive2_pos:
				if (tick)
					next_state = drive2_neg;
			drive2_neg:
				if (tick)
					next_state = latch2_pos;
			latch2_pos:
				if (tick)
					next_state = latch2_neg;
			latch2_neg:
				if (tick)
					next_state = reset_commit ? bus_reset_pos : drive1_pos;
			bus_reset_pos:
				if (tick)
					next_state = bus_reset_neg;
			bus_reset_neg:
				if (tick)
					next_state = repeat_zero ? bus_disable : bus_reset_pos;
			bus_disable:
				if (tick && repeat_zero)
					next_state = bus_idle;
			default:
				next_state = bus_idle;
		endcase
	end

	// reset request is armed on a mismatch, committed one loop later.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			reset_armed <= 1'b0;
			reset_commit <= 1'b0;
		end
		else if (state == bus_idle)
		begin
			reset_armed <= 1'b0;
			reset_commit <= 1'b0;
		end
		else if (state == latch2_pos && !reset_armed && !reset_commit && interject)
			reset_armed <= 1'b1;
		else if (state == drive2_neg && tick && reset_armed)
		begin
			reset_armed <= 1'b0;
			reset_commit <= 1'b1;
		end
	end

	// DOUT is released for the data loops only.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			hold <= 1'b1;
		else if (state == arb_res_neg && tick)
			hold <= 1'b0;
		else if (state == latch2_neg && tick && reset_commit)
			hold <= 1'b1;
	end

	always_comb
	begin
		case (state)
			wait_start_neg, arb_res_neg, drive1_neg, latch1_neg,
			drive2_neg, latch2_neg, bus_reset_neg:
				CLK_OUT = 1'b0;
			default:
				CLK_OUT = 1'b1;
		endcase
	end

	assign run = (state != bus_idle);
	assign load_start = (state == bus_idle) ||
		(state == bus_reset_neg && tick && repeat_zero);
	assign load_reset = (state == latch2_pos);
	assign step = tick && !repeat_zero &&
		(state inside {wait_start_pos, bus_reset_neg, bus_disable});
	assign sample_first = tick && (state == drive1_neg);
	assign sample_second = tick && (state == drive2_neg);
	assign bus_active = state inside {[drive1_pos:latch2_neg]};

endmodule

`default_nettype wire

// ==== logic/bus_data_path.sv ====
`default_nettype none

module bus_data_path
(
	input  logic CLK_IN,
	input  logic RESET,
	input  logic DIN,
	input  logic hold,
	input  logic sample_first,
	input  logic sample_second,
	output logic DOUT,
	output logic din_low,
	output logic interject,
	output logic bit_valid,
	output logic bit_value
);

	logic din_reg;
	logic first_bit;
	logic second_bit;
	logic second_seen;

	// idle ring is high.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			din_reg <= 1'b1;
		else
			din_reg <= DIN;
	end

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			first_bit <= 1'b0;
			second_bit <= 1'b0;
			second_seen <= 1'b0;
		end
		else
		begin
			if (sample_first)
				first_bit <= din_reg;
			if (sample_second)
				second_bit <= din_reg;
			second_seen <= sample_second;
		end
	end

	assign DOUT = hold ? 1'b1 : din_reg;
	assign din_low = !din_reg;
	// samples differ when a node has interjected.
	assign interject = first_bit ^ second_bit;
	assign bit_valid = second_seen && !interject;
	assign bit_value = first_bit;

endmodule

`default_nettype wire

// ==== logic/frame_receiver.sv ====
`default_nettype none

module frame_receiver
	import bus_frame_pkg::*;
(
	input  logic      CLK_IN,
	input  logic      RESET,
	input  logic      bus_active,
	input  logic      bit_valid,
	input  logic      bit_value,
	input  logic      word_ack,
	output logic      word_req,
	output logic      word_is_header,
	output logic      overflow,
	output bus_word_u word_data
);

	logic [word_bits-1:0] shift_reg;
	logic [bit_index_bits-1:0] bit_cnt;
	logic [count_bits-1:0] words_left;
	logic have_header;
	logic frame_done;
	logic active_d;
	logic frame_start;
	logic frame_end;
	logic bit_take;
	logic word_complete;
	logic hs_busy;
	logic deliver;
	bus_word_u next_word;

	assign frame_start = bus_active && !active_d;
	assign frame_end = active_d && !bus_active;
	assign bit_take = bit_valid && !frame_done;
	assign word_complete = bit_take && (bit_cnt == bit_index_bits'(word_bits - 1));
	// busy until the host has dropped ack.
	assign hs_busy = word_req || word_ack;
	assign deliver = word_complete && !hs_busy;
	assign next_word.raw = {shift_reg[word_bits-2:0], bit_value};

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			active_d <= 1'b0;
			bit_cnt <= '0;
			words_left <= '0;
			have_header <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			active_d <= bus_active;
			if (frame_end)
			begin
				bit_cnt <= '0;
				words_left <= '0;
				have_header <= 1'b0;
				frame_done <= 1'b0;
			end
			else if (bit_take)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (word_complete && !have_header)
				begin
					have_header <= 1'b1;
					words_left <= next_word.header.word_count;
					frame_done <= (next_word.header.word_count == '0);
				end
				else if (word_complete)
				begin
					words_left <= words_left - 1'b1;
					frame_done <= (words_left == count_bits'(1));
				end
			end
		end
	end

	// four-phase side of the host interface.
	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			word_req <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			if (deliver)
				word_req <= 1'b1;
			else if (word_req && word_ack)
				word_req <= 1'b0;
			if (frame_start)
				overflow <= 1'b0;
			else if (word_complete && hs_busy)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		if (bit_take)
			shift_reg <= next_word.raw;
		if (deliver)
		begin
			word_data <= next_word;
			word_is_header <= !have_header;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mediator_top.sv ====
`default_nettype none

module mediator_top
	import bus_frame_pkg::*;
(
	input  logic      CLK_IN,
	input  logic      RESET,
	input  logic      DIN,
	input  logic      word_ack,
	output logic      CLK_OUT,
	output logic      DOUT,
	output logic      word_req,
	output logic      word_is_header,
	output logic      overflow,
	output bus_word_u word_data
);

	logic run;
	logic load_start;
	logic load_reset;
	logic step;
	logic tick;
	logic repeat_zero;
	logic hold;
	logic sample_first;
	logic sample_second;
	logic din_low;
	logic interject;
	logic bit_valid;
	logic bit_value;
	logic bus_active;

	half_cycle_timer i_half_cycle_timer
	(
		.CLK_IN      (CLK_IN),
		.RESET       (RESET),
		.run         (run),
		.load_start  (load_start),
		.load_reset  (load_reset),
		.step        (step),
		.tick        (tick),
		.repeat_zero (repeat_zero)
	);

	mediator_fsm i_mediator_fsm
	(
		.CLK_IN        (CLK_IN),
		.RESET         (RESET),
		.din_low       (din_low),
		.interject     (interject),
		.tick          (tick),
		.repeat_zero   (repeat_zero),
		.CLK_OUT       (CLK_OUT),
		.hold          (hold),
		.run           (run),
		.load_start    (load_start),
		.load_reset    (load_reset),
		.step          (step),
		.sample_first  (sample_first),
		.sample_second (sample_second),
		.bus_active    (bus_active)
	);

	bus_data_path i_bus_data_path
	(
		.CLK_IN        (CLK_IN),
		.RESET         (RESET),
		.DIN           (DIN),
		.hold          (hold),
		.sample_first  (sample_first),
		.sample_second (sample_second),
		.DOUT          (DOUT),
		.din_low       (din_low),
		.interject     (interject),
		.bit_valid     (bit_valid),
		.bit_value     (bit_value)
	);

	frame_receiver i_frame_receiver
	(
		.CLK_IN         (CLK_IN),
		.RESET          (RESET),
		.bus_active     (bus_active),
		.bit_valid      (bit_valid),
		.bit_value      (bit_value),
		.word_ack       (word_ack),
		.word_req       (word_req),
		.word_is_header (word_is_header),
		.overflow       (overflow),
		.word_data      (word_data)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
(
	output logic CLK_IN,
	output logic RESET
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		CLK_IN = 1'b0;
		forever
			#10 CLK_IN = ~CLK_IN;
	end

	// release away from the rising edge.
	initial
	begin
		RESET = 1'b0;
		repeat (4) @(posedge CLK_IN);
		@(negedge CLK_IN);
		RESET = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/mediator_tb.sv ====
`default_nettype none

module mediator_tb
	import bus_timing_pkg::*, bus_frame_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_rows = 5;
	// one bit is four bus clocks.
	localparam int word_cycles = word_bits * 8 * clk_divider;

	logic CLK_IN;
	logic RESET;
	logic DIN;
	logic word_ack;
	logic CLK_OUT;
	logic DOUT;
	logic word_req;
	logic word_is_header;
	logic overflow;
	bus_word_u word_data;

	logic [7:0] row_addr [num_rows] = '{8'h3c, 8'h81, 8'h07, 8'h5a, 8'he2};
	int row_count [num_rows] = '{2, 3, 4, 2, 1};
	logic [15:0] row_data [num_rows][4] = '{
		'{16'ha5c3, 16'h0f0f, 16'h0000, 16'h0000},
		'{16'h1234, 16'hffff, 16'h0001, 16'h0000},
		'{16'h8001, 16'h7ffe, 16'h3c5a, 16'hc3a5},
		'{16'hbeef, 16'hcafe, 16'h0000, 16'h0000},
		'{16'h7e81, 16'h0000, 16'h0000, 16'h0000}};
	int row_trail [num_rows] = '{1, 0, 2, 0, 1};
	logic row_inject [num_rows] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
	// row 3 acks slower than one word time.
	int row_delay [num_rows] = '{5, 3, 20, 1500, 0};

	int errors = 0;
	int rows_failed = 0;
	int ack_delay_cur = 0;
	logic ov_expected = 1'b0;
	logic [15:0] got_data[$];
	logic got_hdr[$];
	int limit;

	tb_clock_gen i_tb_clock_gen
	(
		.CLK_IN (CLK_IN),
		.RESET  (RESET)
	);

	mediator_top i_mediator_top
	(
		.CLK_IN         (CLK_IN),
		.RESET          (RESET),
		.DIN            (DIN),
		.word_ack       (word_ack),
		.CLK_OUT        (CLK_OUT),
		.DOUT           (DOUT),
		.word_req       (word_req),
		.word_is_header (word_is_header),
		.overflow       (overflow),
		.word_data      (word_data)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
	begin
		$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
		errors++;
	end
	endtask

	function automatic int watchdog_cycles();
		int total;
		total = 400;
		for (int r = 0; r < num_rows; r++)
		begin
			total += (16 * (1 + row_count[r] + row_trail[r]) + 2) * 8 * clk_divider;
			total += (2 * reset_cycles + 2 * start_half_cycles + 6) * clk_divider;
			total += row_delay[r];
		end
		return 2 * total;
	endfunction

	// host side of the four-phase handshake.
	initial
	begin
		logic [15:0] seen;
		int wait_n;
		word_ack = 1'b0;
		forever
		begin
			@(negedge CLK_IN);
			if (word_req && !word_ack)
			begin
				seen = word_data.raw;
				got_data.push_back(seen);
				got_hdr.push_back(word_is_header);
				wait_n = ack_delay_cur + int'($urandom_range(3, 0));
				repeat (wait_n)
				begin
					@(negedge CLK_IN);
					if (word_data.raw !== seen)
						report_mismatch("word_data", 32'(seen), 32'(word_data.raw));
				end
				word_ack = 1'b1;
				do
				begin
					@(negedge CLK_IN);
					if (word_req && word_data.raw !== seen)
						report_mismatch("word_data", 32'(seen), 32'(word_data.raw));
				end
				while (word_req);
				word_ack = 1'b0;
			end
		end
	end

	task automatic drive_row(input int r);
		logic bit_q[$];
		logic [15:0] words[$];
		logic [15:0] exp_q[$];
		bus_word_u hw;
		mediator_state_e st;
		mediator_state_e prev_st;
		int interject_at;
		int loop_no;
		int run_len;
		int runs_done;
		int reset_lows;
		int last_t;
		int exp_len;
		int start_errors;
		logic cur_level;
		logic seen_disable;
		logic ov_checked;
		logic finished;
		logic dropped;
		logic b_first;
		logic b_second;
		begin
			start_errors = errors;
			hw.header.dest_addr = row_addr[r];
			hw.header.word_count = 8'(row_count[r]);
			words.push_back(hw.raw);
			for (int k = 0; k < row_count[r]; k++)
				words.push_back(row_data[r][k]);
			for (int k = 0; k < row_trail[r]; k++)
				words.push_back(16'($urandom()));
			foreach (words[w])
				for (int i = word_bits - 1; i >= 0; i--)
					bit_q.push_back(words[w][i]);
			interject_at = row_inject[r] ? word_bits + 5 : bit_q.size();

			// a word is lost while the previous handshake is still open.
			dropped = 1'b0;
			exp_q.push_back(hw.raw);
			last_t = 0;
			if (!row_inject[r])
				for (int k = 1; k <= row_count[r]; k++)
				begin
					if (k * word_cycles - last_t > row_delay[r] + 8)
					begin
						exp_q.push_back(row_data[r][k-1]);
						last_t = k * word_cycles;
					end
					else
						dropped = 1'b1;
				end

			if (overflow !== ov_expected)
				report_mismatch("overflow", 32'(ov_expected), 32'(overflow));
			got_data.delete();
			got_hdr.delete();
			ack_delay_cur = row_delay[r];
			DIN = 1'b0;
			prev_st = bus_idle;
			loop_no = 0;
			run_len = 0;
			runs_done = 0;
			reset_lows = 0;
			cur_level = 1'b1;
			seen_disable = 1'b0;
			ov_checked = 1'b0;
			finished = 1'b0;
			b_first = 1'b1;
			b_second = 1'b1;

			while (!finished)
			begin
				@(negedge CLK_IN);
				st = i_mediator_top.i_mediator_fsm.state;
				if (st == bus_idle && seen_disable)
				begin
					if (run_len != start_half_cycles * clk_divider)
						report_mismatch("CLK_OUT disable length",
							32'(start_half_cycles * clk_divider), 32'(run_len));
					finished = 1'b1;
				end
				else
				begin
					if (CLK_OUT == cur_level)
						run_len++;
					else
					begin
						// one idle cycle sees the registered request first.
						exp_len = (runs_done == 0) ?
							start_half_cycles * clk_divider + 1 : clk_divider;
						if (run_len != exp_len)
							report_mismatch("CLK_OUT half-period", 32'(exp_len), 32'(run_len));
						runs_done++;
						cur_level = CLK_OUT;
						run_len = 1;
						if (!CLK_OUT && st == bus_reset_neg)
							reset_lows++;
					end
					if (st == bus_disable)
						seen_disable = 1'b1;
					if (st inside {[drive1_pos:latch2_neg]})
					begin
						if (DOUT !== DIN)
							report_mismatch("DOUT", 32'(DIN), 32'(DOUT));
					end
					else if (DOUT !== 1'b1)
						report_mismatch("DOUT", 32'h1, 32'(DOUT));
					if (st == drive1_neg && !ov_checked)
					begin
						if (overflow !== 1'b0)
							report_mismatch("overflow", 32'h0, 32'(overflow));
						ov_checked = 1'b1;
					end
					// ring model.
					if (st == drive1_pos && prev_st != drive1_pos)
					begin
						if (loop_no < interject_at)
						begin
							b_first = bit_q[loop_no];
							b_second = b_first;
						end
						else if (loop_no == interject_at)
						begin
							b_first = 1'b0;
							b_second = 1'b1;
						end
						else
						begin
							b_first = 1'b1;
							b_second = 1'b1;
						end
						loop_no++;
						DIN = b_first;
					end
					else if (st == drive2_pos && prev_st != drive2_pos)
						DIN = b_second;
					else if (st == bus_reset_pos)
						DIN = 1'b1;
					prev_st = st;
				end
			end

			if (reset_lows != reset_cycles)
				report_mismatch("CLK_OUT reset pulses", 32'(reset_cycles), 32'(reset_lows));
			while (word_req || word_ack)
				@(negedge CLK_IN);
			repeat (2) @(negedge CLK_IN);
			if (got_data.size() != exp_q.size())
				report_mismatch("word count delivered", 32'(exp_q.size()), 32'(got_data.size()));
			else
				foreach (exp_q[i])
				begin
					if (got_data[i] !== exp_q[i])
						report_mismatch("word_data", 32'(exp_q[i]), 32'(got_data[i]));
					if (got_hdr[i] !== (i == 0))
						report_mismatch("word_is_header", 32'(i == 0), 32'(got_hdr[i]));
				end
			ov_expected = dropped;
			if (overflow !== ov_expected)
				report_mismatch("overflow", 32'(ov_expected), 32'(overflow));
			if (errors == start_errors)
				$display("row %0d: ok, %0d words delivered", r, got_data.size());
			else
			begin
				$display("row %0d: %0d errors", r, errors - start_errors);
				rows_failed++;
			end
		end
	endtask

	initial
	begin
		#1;
		limit = watchdog_cycles();
		repeat (limit) @(posedge CLK_IN);
		$display("watchdog: transactions did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		DIN = 1'b1;
		void'($urandom(32'ha19c_db47));
		@(posedge RESET);
		repeat (20)
		begin
			@(negedge CLK_IN);
			if (CLK_OUT !== 1'b1)
				report_mismatch("CLK_OUT", 32'h1, 32'(CLK_OUT));
			if (DOUT !== 1'b1)
				report_mismatch("DOUT", 32'h1, 32'(DOUT));
			if (word_req !== 1'b0)
				report_mismatch("word_req", 32'h0, 32'(word_req));
			if (overflow !== 1'b0)
				report_mismatch("overflow", 32'h0, 32'(overflow));
		end
		$display("idle after reset: %0s", (errors == 0) ? "ok" : "errors");
		for (int r = 0; r < num_rows; r++)
			drive_row(r);
		$display("rows run %0d, rows failed %0d, checks failed %0d",
			num_rows, rows_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/bus_timing_pkg.sv
logic/bus_frame_pkg.sv
logic/half_cycle_timer.sv
logic/mediator_fsm.sv
logic/bus_data_path.sv
logic/frame_receiver.sv
logic/mediator_top.sv
verification/tb_clock_gen.sv
verification/mediator_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= mediator_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
